// File: rtl/vstu.sv
`timescale 1ns/1ps
`default_nettype none

module vstu (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  // Sequencer
  input  wire logic                                          pe_req_valid_i,
  input  wire vstu_pkg::insn_id_t                            pe_req_id_i,
  input  wire vstu_pkg::vl_t                                 pe_req_vl_i,
  input  wire vstu_pkg::vsew_t                               pe_req_vsew_i,
  input  wire logic                                          pe_req_vm_i,
  input  wire vstu_pkg::vinsn_vec_t                          pe_vinsn_running_i,
  output      logic                                          pe_req_ready_o,
  output      vstu_pkg::vinsn_vec_t                          pe_vinsn_done_o,
  output      logic                                          store_pending_o,
  output      logic                                          store_complete_o,
  // Address generator
  input  wire logic                                          addrgen_valid_i,
  input  wire vstu_pkg::burst_len_t                          addrgen_len_i,
  input  wire logic                                          addrgen_exception_i,
  output      logic                                          addrgen_ready_o,
  // Lanes and mask unit
  input  wire vstu_pkg::elen_t      [vstu_pkg::NR_LANES-1:0] operand_i,
  input  wire logic                 [vstu_pkg::NR_LANES-1:0] operand_valid_i,
  output      logic                 [vstu_pkg::NR_LANES-1:0] operand_ready_o,
  input  wire vstu_pkg::lane_strb_t [vstu_pkg::NR_LANES-1:0] mask_i,
  input  wire logic                 [vstu_pkg::NR_LANES-1:0] mask_valid_i,
  output      logic                                          mask_ready_o,
  output      logic                                          exception_flush_o,
  // Memory write and response channels
  output      logic                                          w_valid_o,
  input  wire logic                                          w_ready_i,
  output      vstu_pkg::w_data_t                             w_data_o,
  output      vstu_pkg::w_strb_t                             w_strb_o,
  output      logic                                          w_last_o,
  input  wire logic                                          b_valid_i,
  output      logic                                          b_ready_o
);

  // Registered lane operands
  vstu_pkg::elen_t [vstu_pkg::NR_LANES-1:0] op_data;
  logic            [vstu_pkg::NR_LANES-1:0] op_valid;
  logic            [vstu_pkg::NR_LANES-1:0] op_ready;

  // Issue handshake between queue and packer
  logic            issue_valid;
  vstu_pkg::vl_t   issue_vl;
  vstu_pkg::vsew_t issue_vsew;
  logic            issue_vm;
  logic            issue_done;
  logic            issue_abort;

  vstu_operand_regs i_operand_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .exception_i    (exception_flush_o),
    .operand_o      (op_data),
    .operand_valid_o(op_valid),
    .operand_ready_i(op_ready)
  );

  vstu_insn_queue i_insn_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .pe_req_valid_i    (pe_req_valid_i),
    .pe_req_id_i       (pe_req_id_i),
    .pe_req_vl_i       (pe_req_vl_i),
    .pe_req_vsew_i     (pe_req_vsew_i),
    .pe_req_vm_i       (pe_req_vm_i),
    .pe_vinsn_running_i(pe_vinsn_running_i),
    .pe_req_ready_o    (pe_req_ready_o),
    .pe_vinsn_done_o   (pe_vinsn_done_o),
    .store_pending_o   (store_pending_o),
    .store_complete_o  (store_complete_o),
    .issue_valid_o     (issue_valid),
    .issue_vl_o        (issue_vl),
    .issue_vsew_o      (issue_vsew),
    .issue_vm_o        (issue_vm),
    .issue_done_i      (issue_done),
    .issue_abort_i     (issue_abort),
    .b_valid_i         (b_valid_i),
    .b_ready_o         (b_ready_o)
  );

  vstu_w_packer i_w_packer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .issue_valid_i      (issue_valid),
    .issue_vl_i         (issue_vl),
    .issue_vsew_i       (issue_vsew),
    .issue_vm_i         (issue_vm),
    .issue_done_o       (issue_done),
    .issue_abort_o      (issue_abort),
    .addrgen_valid_i    (addrgen_valid_i),
    .addrgen_len_i      (addrgen_len_i),
    .addrgen_exception_i(addrgen_exception_i),
    .addrgen_ready_o    (addrgen_ready_o),
    .operand_i          (op_data),
    .operand_valid_i    (op_valid),
    .operand_ready_o    (op_ready),
    .mask_i             (mask_i),
    .mask_valid_i       (mask_valid_i),
    .mask_ready_o       (mask_ready_o),
    .w_valid_o          (w_valid_o),
    .w_ready_i          (w_ready_i),
    .w_data_o           (w_data_o),
    .w_strb_o           (w_strb_o),
    .w_last_o           (w_last_o),
    .exception_flush_o  (exception_flush_o)
  );

endmodule

`default_nettype wire

// File: rtl/vstu_insn_queue.sv
`timescale 1ns/1ps
`default_nettype none

module vstu_insn_queue (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 pe_req_valid_i,
  input  wire vstu_pkg::insn_id_t   pe_req_id_i,
  input  wire vstu_pkg::vl_t        pe_req_vl_i,
  input  wire vstu_pkg::vsew_t      pe_req_vsew_i,
  input  wire logic                 pe_req_vm_i,
  input  wire vstu_pkg::vinsn_vec_t pe_vinsn_running_i,
  output      logic                 pe_req_ready_o,
  output      vstu_pkg::vinsn_vec_t pe_vinsn_done_o,
  output      logic                 store_pending_o,
  output      logic                 store_complete_o,
  output      logic                 issue_valid_o,
  output      vstu_pkg::vl_t        issue_vl_o,
  output      vstu_pkg::vsew_t      issue_vsew_o,
  output      logic                 issue_vm_o,
  input  wire logic                 issue_done_i,
  input  wire logic                 issue_abort_i,
  input  wire logic                 b_valid_i,
  output      logic                 b_ready_o
);

  localparam int unsigned DEPTH = vstu_pkg::QUEUE_DEPTH;

  // Instruction storage
  vstu_pkg::insn_id_t id_q   [DEPTH];
  vstu_pkg::vl_t      vl_q   [DEPTH];
  vstu_pkg::vsew_t    vsew_q [DEPTH];
  logic               vm_q   [DEPTH];
  logic [DEPTH-1:0]   aborted_q;

  vstu_pkg::queue_ptr_t accept_pnt_q, issue_pnt_q, commit_pnt_q;
  vstu_pkg::queue_cnt_t issue_cnt_q, commit_cnt_q;
  // B responses that arrived before their instruction reached the commit head
  vstu_pkg::queue_cnt_t b_credit_q;
  vstu_pkg::vinsn_vec_t running_q;

  logic accept;
  logic head_issued;
  logic head_aborted;
  logic b_take;
  logic retire;
  logic use_credit;

  //////////////////////////////
  // Accept and issue
  //////////////////////////////

  assign pe_req_ready_o  = (commit_cnt_q != vstu_pkg::queue_cnt_t'(DEPTH));
  assign accept          = pe_req_valid_i && pe_req_ready_o && !running_q[pe_req_id_i];
  assign store_pending_o = (commit_cnt_q != '0);

  // Head of the issue phase
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_vl_o    = vl_q[issue_pnt_q];
  assign issue_vsew_o  = vsew_q[issue_pnt_q];
  assign issue_vm_o    = vm_q[issue_pnt_q];

  //////////////////////////////
  // Commit
  //////////////////////////////

  // Oldest entry has left the issue phase
  assign head_issued  = (commit_cnt_q != issue_cnt_q);
  assign head_aborted = aborted_q[commit_pnt_q];

  // Every B is acked, but only counted when a store is waiting for it
  assign b_ready_o  = b_valid_i;
  assign b_take     = b_valid_i && head_issued;
  // Aborted entries retire without a response
  assign retire     = head_issued && (head_aborted || b_take || b_credit_q != '0);
  assign use_credit = retire && !head_aborted;

  assign store_complete_o = retire;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q    <= '0;
      issue_pnt_q     <= '0;
      commit_pnt_q    <= '0;
      issue_cnt_q     <= '0;
      commit_cnt_q    <= '0;
      b_credit_q      <= '0;
      running_q       <= '0;
      aborted_q       <= '0;
      pe_vinsn_done_o <= '0;
    end else begin
      accept_pnt_q <= accept_pnt_q + vstu_pkg::queue_ptr_t'(accept);
      issue_pnt_q  <= issue_pnt_q + vstu_pkg::queue_ptr_t'(issue_done_i);
      commit_pnt_q <= commit_pnt_q + vstu_pkg::queue_ptr_t'(retire);
      issue_cnt_q  <= issue_cnt_q + vstu_pkg::queue_cnt_t'(accept)
                      - vstu_pkg::queue_cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + vstu_pkg::queue_cnt_t'(accept)
                      - vstu_pkg::queue_cnt_t'(retire);
      b_credit_q   <= b_credit_q + vstu_pkg::queue_cnt_t'(b_take)
                      - vstu_pkg::queue_cnt_t'(use_credit);

      // Sequencer clears ids as they finish everywhere
      running_q <= (running_q & pe_vinsn_running_i)
                   | (vstu_pkg::vinsn_vec_t'(accept) << pe_req_id_i);

      if (issue_done_i && issue_abort_i) begin
        aborted_q[issue_pnt_q] <= 1'b1;
      end
      if (accept) begin
        aborted_q[accept_pnt_q] <= 1'b0;
      end

      // Done bit shows one cycle after the retire
      pe_vinsn_done_o <= vstu_pkg::vinsn_vec_t'(retire) << id_q[commit_pnt_q];
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]   <= pe_req_id_i;
      vl_q[accept_pnt_q]   <= pe_req_vl_i;
      vsew_q[accept_pnt_q] <= pe_req_vsew_i;
      vm_q[accept_pnt_q]   <= pe_req_vm_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/vstu_operand_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vstu_operand_regs (
  input  wire logic                                               clk_i,
  input  wire logic                                               rst_ni,
  input  wire vstu_pkg::elen_t [vstu_pkg::NR_LANES-1:0]           operand_i,
  input  wire logic            [vstu_pkg::NR_LANES-1:0]           operand_valid_i,
  output      logic            [vstu_pkg::NR_LANES-1:0]           operand_ready_o,
  input  wire logic                                               exception_i,
  output      vstu_pkg::elen_t [vstu_pkg::NR_LANES-1:0]           operand_o,
  output      logic            [vstu_pkg::NR_LANES-1:0]           operand_valid_o,
  input  wire logic            [vstu_pkg::NR_LANES-1:0]           operand_ready_i
);

  localparam int unsigned CNT_W = $clog2(vstu_pkg::STU_EX_LAT + 1);

  logic [CNT_W-1:0] flush_cnt_q;
  logic             flush;

  //////////////////////////////
  // Exception flush delay
  //////////////////////////////

  // Lane queues drop their data STU_EX_LAT cycles after the exception
  assign flush = (flush_cnt_q == CNT_W'(vstu_pkg::STU_EX_LAT));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_cnt_q <= '0;
    end else if (flush) begin
      flush_cnt_q <= '0;
    end else if (exception_i || flush_cnt_q != '0) begin
      flush_cnt_q <= flush_cnt_q + CNT_W'(1);
    end
  end

  //////////////////////////////
  // Fall-through registers
  //////////////////////////////

  for (genvar lane = 0; lane < vstu_pkg::NR_LANES; lane++) begin : gen_lane
    vstu_pkg::elen_t data_q;
    logic            full_q;

    // Empty register passes the lane straight through
    assign operand_o[lane]       = full_q ? data_q : operand_i[lane];
    assign operand_valid_o[lane] = full_q | operand_valid_i[lane];
    assign operand_ready_o[lane] = !full_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        full_q <= 1'b0;
      end else if (flush) begin
        full_q <= 1'b0;
      end else if (full_q) begin
        full_q <= !operand_ready_i[lane];
      end else begin
        // Park the word only when the packer does not take it
        full_q <= operand_valid_i[lane] && !operand_ready_i[lane];
      end
    end

    always_ff @(posedge clk_i) begin
      if (!full_q) begin
        data_q <= operand_i[lane];
      end
    end
  end : gen_lane

endmodule

`default_nettype wire

// File: rtl/vstu_pkg.sv
`default_nettype none

package vstu_pkg;

  //////////////////////////////
  // Sizing
  //////////////////////////////

  // Lanes feeding the store unit
  localparam int unsigned NR_LANES    = 2;
  // Bytes in one lane operand
  localparam int unsigned ELEN_BYTES  = 8;
  // One register word is one write beat
  localparam int unsigned WORD_BYTES  = NR_LANES * ELEN_BYTES;
  // Instructions in flight
  localparam int unsigned QUEUE_DEPTH = 4;
  // Instruction ids known to the sequencer
  localparam int unsigned NR_VINSN    = 8;
  // Largest vector length in elements
  localparam int unsigned MAX_VL      = 64;
  // Cycles from an exception to the operand clear
  localparam int unsigned STU_EX_LAT  = 2;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  typedef logic [ELEN_BYTES*8-1:0] elen_t;
  typedef logic [ELEN_BYTES-1:0]   lane_strb_t;
  typedef logic [WORD_BYTES*8-1:0] w_data_t;
  typedef logic [WORD_BYTES-1:0]   w_strb_t;

  typedef logic [$clog2(NR_VINSN)-1:0] insn_id_t;
  typedef logic [NR_VINSN-1:0]         vinsn_vec_t;

  // Element count and log2 of element bytes
  typedef logic [$clog2(MAX_VL+1)-1:0] vl_t;
  typedef logic [1:0]                  vsew_t;

  // Bytes of the widest store of MAX_VL elements with 8 bytes each
  typedef logic [$clog2(MAX_VL*8+1)-1:0] byte_cnt_t;
  // AXI style burst length in beats minus one
  typedef logic [7:0]                    burst_len_t;

  typedef logic [$clog2(QUEUE_DEPTH)-1:0]   queue_ptr_t;
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_cnt_t;

endpackage

`default_nettype wire

// File: rtl/vstu_w_packer.sv
`timescale 1ns/1ps
`default_nettype none

module vstu_w_packer (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  input  wire logic                                          issue_valid_i,
  input  wire vstu_pkg::vl_t                                 issue_vl_i,
  input  wire vstu_pkg::vsew_t                               issue_vsew_i,
  input  wire logic                                          issue_vm_i,
  output      logic                                          issue_done_o,
  output      logic                                          issue_abort_o,
  input  wire logic                                          addrgen_valid_i,
  input  wire vstu_pkg::burst_len_t                          addrgen_len_i,
  input  wire logic                                          addrgen_exception_i,
  output      logic                                          addrgen_ready_o,
  input  wire vstu_pkg::elen_t      [vstu_pkg::NR_LANES-1:0] operand_i,
  input  wire logic                 [vstu_pkg::NR_LANES-1:0] operand_valid_i,
  output      logic                 [vstu_pkg::NR_LANES-1:0] operand_ready_o,
  input  wire vstu_pkg::lane_strb_t [vstu_pkg::NR_LANES-1:0] mask_i,
  input  wire logic                 [vstu_pkg::NR_LANES-1:0] mask_valid_i,
  output      logic                                          mask_ready_o,
  output      logic                                          w_valid_o,
  input  wire logic                                          w_ready_i,
  output      vstu_pkg::w_data_t                             w_data_o,
  output      vstu_pkg::w_strb_t                             w_strb_o,
  output      logic                                          w_last_o,
  output      logic                                          exception_flush_o
);

  localparam int unsigned WB = vstu_pkg::WORD_BYTES;
  localparam int unsigned EB = vstu_pkg::ELEN_BYTES;

  // Bytes already sent for the instruction at issue
  vstu_pkg::byte_cnt_t  byte_cnt_q;
  // Beats already sent in the current burst
  vstu_pkg::burst_len_t beat_cnt_q;

  vstu_pkg::byte_cnt_t total_bytes;
  vstu_pkg::byte_cnt_t remaining;
  vstu_pkg::byte_cnt_t valid_bytes;
  logic                fire;
  logic                burst_last;
  logic                insn_last;
  logic                exception;

  //////////////////////////////
  // Byte accounting
  //////////////////////////////

  assign total_bytes = vstu_pkg::byte_cnt_t'(issue_vl_i) << issue_vsew_i;
  assign remaining   = total_bytes - byte_cnt_q;
  // Short final beat when the store is not a whole number of words
  assign valid_bytes = (remaining < vstu_pkg::byte_cnt_t'(WB)) ? remaining
                                                               : vstu_pkg::byte_cnt_t'(WB);

  // Beat needs the instruction, a clean burst, every lane, and the mask if used
  // vm high means the store is unmasked
  assign w_valid_o = issue_valid_i && addrgen_valid_i && !addrgen_exception_i
                     && (&operand_valid_i) && (issue_vm_i || (&mask_valid_i));
  assign fire      = w_valid_o && w_ready_i;

  assign burst_last = (beat_cnt_q == addrgen_len_i);
  assign insn_last  = (remaining <= vstu_pkg::byte_cnt_t'(WB));
  assign w_last_o   = w_valid_o && burst_last;

  // Faulty burst kills the instruction before any beat leaves
  assign exception = issue_valid_i && addrgen_valid_i && addrgen_exception_i;

  assign issue_done_o      = (fire && insn_last) || exception;
  assign issue_abort_o     = exception;
  assign exception_flush_o = exception;
  assign addrgen_ready_o   = (fire && burst_last) || exception;

  // One beat consumes a whole register word
  assign operand_ready_o = {vstu_pkg::NR_LANES{fire}};
  assign mask_ready_o    = fire && !issue_vm_i;

  //////////////////////////////
  // Beat assembly
  //////////////////////////////

  always_comb begin
    w_data_o = '0;
    w_strb_o = '0;
    for (int unsigned b = 0; b < WB; b++) begin
      // Bytes sit in lane order, lane 0 lowest
      if (vstu_pkg::byte_cnt_t'(b) < valid_bytes) begin
        w_data_o[8*b +: 8] = operand_i[b / EB][8*(b % EB) +: 8];
        w_strb_o[b]        = issue_vm_i || mask_i[b / EB][b % EB];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
      beat_cnt_q <= '0;
    end else if (exception) begin
      byte_cnt_q <= '0;
      beat_cnt_q <= '0;
    end else if (fire) begin
      byte_cnt_q <= insn_last ? '0 : byte_cnt_q + valid_bytes;
      // Next burst or next instruction starts its beat count afresh
      beat_cnt_q <= (burst_last || insn_last) ? '0
                                              : beat_cnt_q + vstu_pkg::burst_len_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held low for 8 cycles, released off the edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #0.5 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/tb_vstu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vstu;

  // Instructions over all tests and a generous cycle budget for each
  localparam int N_INSN      = 25;
  localparam int STIM_CYCLES = N_INSN * 100 + 8;
  localparam int MAX_BEATS   = 32;

  logic                                          clk_i, rst_ni;
  logic                                          pe_req_valid_i, pe_req_vm_i;
  vstu_pkg::insn_id_t                            pe_req_id_i;
  vstu_pkg::vl_t                                 pe_req_vl_i;
  vstu_pkg::vsew_t                               pe_req_vsew_i;
  vstu_pkg::vinsn_vec_t                          pe_vinsn_running_i, pe_vinsn_done_o;
  logic                                          pe_req_ready_o, store_pending_o;
  logic                                          store_complete_o;
  logic                                          addrgen_valid_i, addrgen_exception_i;
  vstu_pkg::burst_len_t                          addrgen_len_i;
  logic                                          addrgen_ready_o;
  vstu_pkg::elen_t      [vstu_pkg::NR_LANES-1:0] operand_i;
  logic                 [vstu_pkg::NR_LANES-1:0] operand_valid_i, operand_ready_o;
  vstu_pkg::lane_strb_t [vstu_pkg::NR_LANES-1:0] mask_i;
  logic                 [vstu_pkg::NR_LANES-1:0] mask_valid_i;
  logic                                          mask_ready_o, exception_flush_o;
  logic                                          w_valid_o, w_ready_i, w_last_o;
  vstu_pkg::w_data_t                             w_data_o;
  vstu_pkg::w_strb_t                             w_strb_o;
  logic                                          b_valid_i, b_ready_o;

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  vstu i_vstu (.*);

  int unsigned          rng_state = 70026;
  int                   errors;
  int                   tests;
  int                   ready_pct = 70;
  vstu_pkg::vinsn_vec_t tb_running;

  // Accepted instructions in acceptance order
  int q_id[$], q_vl[$], q_vsew[$], q_vm[$], q_exc[$];

  // Operands and masks of the instruction being streamed
  vstu_pkg::elen_t      words [MAX_BEATS][vstu_pkg::NR_LANES];
  vstu_pkg::lane_strb_t masks [MAX_BEATS][vstu_pkg::NR_LANES];
  int                   cur_vm;
  int                   cur_bytes;

  // Expected W beats popped by the comparing process
  vstu_pkg::w_data_t exp_data_q[$];
  vstu_pkg::w_strb_t exp_strb_q[$];
  logic              exp_last_q[$];

  function int unsigned rand_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function bit chance(input int pct);
    return (rand_next() % 100) < pct;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Lane 0 fills the low bytes and nothing lands past the byte count
  function automatic vstu_pkg::w_data_t ref_data(input int beat);
    vstu_pkg::w_data_t d;
    int                pos;
    d = '0;
    for (int b = 0; b < vstu_pkg::WORD_BYTES; b++) begin
      pos = beat * vstu_pkg::WORD_BYTES + b;
      if (pos < cur_bytes)
        d[8*b +: 8] = words[beat][b / vstu_pkg::ELEN_BYTES][8*(b % vstu_pkg::ELEN_BYTES) +: 8];
    end
    return d;
  endfunction

  function automatic vstu_pkg::w_strb_t ref_strb(input int beat);
    vstu_pkg::w_strb_t s;
    int                pos;
    s = '0;
    for (int b = 0; b < vstu_pkg::WORD_BYTES; b++) begin
      pos = beat * vstu_pkg::WORD_BYTES + b;
      if (pos < cur_bytes)
        s[b] = cur_vm ? 1'b1 : masks[beat][b / vstu_pkg::ELEN_BYTES][b % vstu_pkg::ELEN_BYTES];
    end
    return s;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_data(input vstu_pkg::w_data_t got, input vstu_pkg::w_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: W data %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_strb(input vstu_pkg::w_strb_t got, input vstu_pkg::w_strb_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: W strobes %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_done(input vstu_pkg::vinsn_vec_t got, input vstu_pkg::vinsn_vec_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: done vector %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Comparing process checks every transferred beat against the model
  always @(negedge clk_i) begin
    if (rst_ni && w_valid_o && w_ready_i) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("Unexpected W beat at %0t with no store waiting for it", $time);
      end else begin
        check_data(w_data_o, exp_data_q.pop_front());
        check_strb(w_strb_o, exp_strb_q.pop_front());
        check_flag("w_last_o", w_last_o, exp_last_q.pop_front());
      end
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Step to just after the next rising edge with every input idle
  task automatic next_cycle();
    @(posedge clk_i);
    #0.5;
    pe_req_valid_i      = 1'b0;
    pe_vinsn_running_i  = tb_running;
    operand_valid_i     = '0;
    mask_valid_i        = '0;
    addrgen_valid_i     = 1'b0;
    addrgen_exception_i = 1'b0;
    addrgen_len_i       = '0;
    w_ready_i           = 1'b0;
    b_valid_i           = 1'b0;
  endtask

  task automatic send_req(input int id, input int vm, input int exc);
    int vl;
    int vsew;
    vl   = 1 + rand_next() % vstu_pkg::MAX_VL;
    vsew = rand_next() % 4;
    next_cycle();
    tb_running[id]     = 1'b1;
    pe_vinsn_running_i = tb_running;
    pe_req_valid_i     = 1'b1;
    pe_req_id_i        = id;
    pe_req_vl_i        = vl;
    pe_req_vsew_i      = vsew;
    pe_req_vm_i        = vm;
    @(negedge clk_i);
    check_flag("pe_req_ready_o", pe_req_ready_o, 1'b1);
    q_id.push_back(id);
    q_vl.push_back(vl);
    q_vsew.push_back(vsew);
    q_vm.push_back(vm);
    q_exc.push_back(exc);
  endtask

  // Request with an id that is still running must be refused
  task automatic try_busy(input int id, input int n);
    repeat (n) begin
      next_cycle();
      pe_req_valid_i = 1'b1;
      pe_req_id_i    = id;
      pe_req_vm_i    = 1'b1;
    end
  endtask

  task automatic send_b(input int id);
    next_cycle();
    b_valid_i = 1'b1;
    @(negedge clk_i);
    check_flag("b_ready_o", b_ready_o, 1'b1);
    check_flag("store_complete_o", store_complete_o, 1'b1);
    next_cycle();
    @(negedge clk_i);
    check_flag("b_ready_o", b_ready_o, 1'b0);
    check_done(pe_vinsn_done_o, vstu_pkg::vinsn_vec_t'(1) << id);
    tb_running[id] = 1'b0;
  endtask

  task automatic stream_insn(input bit do_b);
    int id, vm, exc, nbeats, rem, len, seen, bidx, midx;
    int lane_idx [vstu_pkg::NR_LANES];
    int lens[$];
    id        = q_id.pop_front();
    cur_bytes = q_vl.pop_front() << q_vsew.pop_front();
    vm        = q_vm.pop_front();
    exc       = q_exc.pop_front();
    cur_vm    = vm;
    nbeats    = (cur_bytes + vstu_pkg::WORD_BYTES - 1) / vstu_pkg::WORD_BYTES;
    if (exc) begin
      // Faulty burst at issue lets no beat leave
      next_cycle();
      addrgen_valid_i     = 1'b1;
      addrgen_exception_i = 1'b1;
      // Lanes and mask offer a word so only the fault holds the beat back
      // Words parked here must be gone before the next store streams
      operand_valid_i     = '1;
      mask_valid_i        = '1;
      w_ready_i           = 1'b1;
      @(negedge clk_i);
      check_flag("addrgen_ready_o", addrgen_ready_o, 1'b1);
      check_flag("exception_flush_o", exception_flush_o, 1'b1);
      check_flag("w_valid_o", w_valid_o, 1'b0);
      next_cycle();
      @(negedge clk_i);
      check_flag("store_complete_o", store_complete_o, 1'b1);
      next_cycle();
      @(negedge clk_i);
      check_done(pe_vinsn_done_o, vstu_pkg::vinsn_vec_t'(1) << id);
      tb_running[id] = 1'b0;
      return;
    end
    for (int i = 0; i < nbeats; i++) begin
      for (int l = 0; l < vstu_pkg::NR_LANES; l++) begin
        words[i][l] = {rand_next(), rand_next()};
        masks[i][l] = vstu_pkg::lane_strb_t'(rand_next());
      end
      exp_data_q.push_back(ref_data(i));
      exp_strb_q.push_back(ref_strb(i));
    end
    // Random burst split with the last flag on each burst end
    rem = nbeats;
    while (rem > 0) begin
      len = 1 + rand_next() % ((rem < 8) ? rem : 8);
      lens.push_back(len - 1);
      for (int k = 0; k < len; k++) exp_last_q.push_back(k == len - 1);
      rem -= len;
    end
    seen = 0;
    bidx = 0;
    midx = 0;
    foreach (lane_idx[l]) lane_idx[l] = 0;
    while (seen < nbeats) begin
      next_cycle();
      for (int l = 0; l < vstu_pkg::NR_LANES; l++) begin
        operand_valid_i[l] = (lane_idx[l] < nbeats) && chance(70);
        operand_i[l]       = (lane_idx[l] < nbeats) ? words[lane_idx[l]][l] : '0;
        mask_i[l]          = (midx < nbeats) ? masks[midx][l] : '0;
      end
      mask_valid_i    = (!vm && midx < nbeats && chance(70)) ? '1 : '0;
      addrgen_valid_i = (bidx < lens.size());
      addrgen_len_i   = (bidx < lens.size()) ? lens[bidx] : '0;
      w_ready_i       = chance(ready_pct);
      @(negedge clk_i);
      // Unmasked stores never take a mask
      if (vm) check_flag("mask_ready_o", mask_ready_o, 1'b0);
      for (int l = 0; l < vstu_pkg::NR_LANES; l++)
        if (operand_valid_i[l] && operand_ready_o[l]) lane_idx[l]++;
      if (mask_valid_i[0] && mask_ready_o) midx++;
      if (addrgen_ready_o) bidx++;
      if (w_valid_o && w_ready_i) seen++;
    end
    if (bidx != lens.size()) begin
      errors++;
      $display("Address bursts were not all acknowledged by the end of the store");
    end
    if (do_b) send_b(id);
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    if (exp_data_q.size() != 0) begin
      errors++;
      $display("Store beats never appeared on the W channel");
      exp_data_q.delete();
      exp_strb_q.delete();
      exp_last_q.delete();
    end
    next_cycle();
    @(negedge clk_i);
    check_flag("store_pending_o", store_pending_o, 1'b0);
    $display("Test %0d %s: %0d errors", tests, name, errors - err0);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int err0;
    errors = 0;
    tests  = 0;
    tb_running = '0;
    pe_req_valid_i = 1'b0;
    pe_req_id_i = '0;
    pe_req_vl_i = '0;
    pe_req_vsew_i = '0;
    pe_req_vm_i = 1'b0;
    pe_vinsn_running_i = '0;
    operand_i = '0;
    operand_valid_i = '0;
    mask_i = '0;
    mask_valid_i = '0;
    addrgen_valid_i = 1'b0;
    addrgen_exception_i = 1'b0;
    addrgen_len_i = '0;
    w_ready_i = 1'b0;
    b_valid_i = 1'b0;
    @(posedge rst_ni);
    @(negedge clk_i);
    check_flag("pe_req_ready_o", pe_req_ready_o, 1'b1);
    check_flag("store_pending_o", store_pending_o, 1'b0);

    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      send_req(i, 1, 0);
      stream_insn(1);
    end
    finish_test("unmasked", err0);

    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      send_req(i + 4, 0, 0);
      stream_insn(1);
    end
    finish_test("masked", err0);

    // Fill the queue with a refused duplicate id in between
    err0 = errors;
    send_req(0, 1, 0);
    try_busy(0, 3);
    for (int i = 1; i < 4; i++) send_req(i, i % 2, 0);
    next_cycle();
    @(negedge clk_i);
    check_flag("pe_req_ready_o", pe_req_ready_o, 1'b0);
    check_flag("store_pending_o", store_pending_o, 1'b1);
    repeat (4) stream_insn(1);
    next_cycle();
    @(negedge clk_i);
    check_flag("store_pending_o", store_pending_o, 1'b0);
    // Id 0 is free again once the running bit has cleared
    send_req(0, 0, 0);
    next_cycle();
    @(negedge clk_i);
    check_flag("store_pending_o", store_pending_o, 1'b1);
    stream_insn(1);
    finish_test("queue", err0);

    // All stores first and then responses in acceptance order
    err0 = errors;
    for (int i = 0; i < 3; i++) send_req(5 + i, i % 2, 0);
    repeat (3) stream_insn(0);
    for (int i = 0; i < 3; i++) send_b(5 + i);
    finish_test("responses", err0);

    err0 = errors;
    send_req(1, 1, 0);
    send_req(2, 0, 1);
    send_req(3, 0, 0);
    repeat (3) stream_insn(1);
    finish_test("exception", err0);

    err0 = errors;
    ready_pct = 25;
    for (int i = 0; i < 6; i++) begin
      send_req(i, rand_next() % 2, 0);
      stream_insn(1);
    end
    finish_test("backpressure", err0);

    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog at 20 times the stimulus length
  initial begin
    #(20 * STIM_CYCLES * 4);
    $display("Watchdog expired before the tests finished");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vstu.f
rtl/vstu_pkg.sv
rtl/vstu_operand_regs.sv
rtl/vstu_insn_queue.sv
rtl/vstu_w_packer.sv
rtl/vstu.sv
tests/tb_clk_gen.sv
tests/tb_vstu.sv
